// File: regfile.f
+incdir+include
source/regfile_pkg.sv
source/write_capture.sv
source/register_array.sv
source/read_ports.sv
source/regfile_top.sv
tb/clock_gen.sv
tb/regfile_tb.sv

// File: tb/regfile_tb.sv
// Testbench of the shared CPU/VPU register file
// Directed and random writes on all sources are compared each cycle with a model

`timescale 1ns/10ps

`include "regfile_config.svh"

module regfile_tb import regfile_pkg::*;;

    localparam int RESET_TIMEOUT = 20;
    localparam int RANDOM_CYCLES = 400;
    localparam int MAX_CYCLES    = 1000;

    logic       clk;
    logic       arst_n;
    reg_addr_t  rd_addr_0;
    reg_addr_t  rd_addr_1;
    reg_addr_t  wr_addr_0;
    reg_addr_t  wr_addr_1;
    reg_word_t  wr_data_0;
    reg_word_t  wr_data_1;
    logic       wr_en_0;
    logic       wr_en_1;
    logic       vpu_we;
    reg_word_t  vpu_ro;
    reg_word_t  vpu_vertex [`VERTEX_COUNT];
    logic       flags_we;
    cpu_flags_t flags;
    logic       key_we;
    key_bits_t  keys;
    reg_word_t  rd_data_0;
    reg_word_t  rd_data_1;
    reg_word_t  ro_word;
    reg_word_t  vertex_words [`VERTEX_COUNT];

    integer seed = 32'h0cde_395a;
    int     checks_done = 0;

    // Reference model and its one-entry pending request
    reg_word_t  model_regs [`REG_COUNT];
    logic       p_en_a, p_en_b, p_vpu_we, p_flags_we, p_key_we;
    reg_addr_t  p_addr_a, p_addr_b;
    reg_word_t  p_data_a, p_data_b, p_ro;
    reg_word_t  p_vertex [`VERTEX_COUNT];
    cpu_flags_t p_flags;
    key_bits_t  p_keys;

    clock_gen clock_gen_inst (.clk(clk), .arst_n(arst_n));

    regfile_top regfile_top_inst (
        .clk(clk), .arst_n(arst_n),
        .rd_addr_0(rd_addr_0), .rd_addr_1(rd_addr_1),
        .wr_addr_0(wr_addr_0), .wr_addr_1(wr_addr_1),
        .wr_data_0(wr_data_0), .wr_data_1(wr_data_1),
        .wr_en_0(wr_en_0), .wr_en_1(wr_en_1),
        .vpu_we(vpu_we), .vpu_ro(vpu_ro), .vpu_vertex(vpu_vertex),
        .flags_we(flags_we), .flags(flags), .key_we(key_we), .keys(keys),
        .rd_data_0(rd_data_0), .rd_data_1(rd_data_1),
        .ro_word(ro_word), .vertex_words(vertex_words)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Next value of one register for one request
    function automatic reg_word_t ref_next(
        input int idx, input reg_word_t cur,
        input logic en_a, input reg_addr_t addr_a, input reg_word_t data_a,
        input logic en_b, input reg_addr_t addr_b, input reg_word_t data_b,
        input logic vpu_wr, input reg_word_t vpu_word,
        input logic flags_wr, input cpu_flags_t new_flags,
        input logic key_wr, input key_bits_t new_keys);
        reg_word_t w;
        logic      vpu_reg;
        w = cur;
        vpu_reg = (idx == `RO_REG_IDX) || (idx >= `VERTEX_BASE_IDX &&
                  idx < `VERTEX_BASE_IDX + `VERTEX_COUNT);
        if (vpu_reg && vpu_wr) begin
            w = vpu_word;
        end else if (idx == `FLAGS_REG_IDX && flags_wr) begin
            w[`FLAG_BITS-1:0] = new_flags;
        end else if (idx == `FLAGS_REG_IDX && key_wr) begin
            w[`KEY_LSB +: `KEY_BITS] = cur[`KEY_LSB +: `KEY_BITS] | new_keys;
        end else if (en_a && addr_a == idx) begin
            w = data_a;
        end else if (en_b && addr_b == idx) begin
            w = data_b;
        end
        return w;
    endfunction

    task automatic apply_pending();
        reg_word_t vw;
        for (int i = 0; i < `REG_COUNT; i++) begin
            vw = '0;
            if (i == `RO_REG_IDX) begin
                vw = p_ro;
            end else if (i >= `VERTEX_BASE_IDX) begin
                vw = p_vertex[i - `VERTEX_BASE_IDX];
            end
            model_regs[i] = ref_next(i, model_regs[i], p_en_a, p_addr_a, p_data_a,
                                     p_en_b, p_addr_b, p_data_b, p_vpu_we, vw,
                                     p_flags_we, p_flags, p_key_we, p_keys);
        end
    endtask

    // Oldest request lands and the current inputs become the pending one
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                model_regs[i] = '0;
            end
            {p_en_a, p_en_b, p_vpu_we, p_flags_we, p_key_we} = '0;
        end else begin
            apply_pending();
            p_en_a = wr_en_0;
            p_addr_a = wr_addr_0;
            p_data_a = wr_data_0;
            p_en_b = wr_en_1;
            p_addr_b = wr_addr_1;
            p_data_b = wr_data_1;
            p_vpu_we = vpu_we;
            p_ro = vpu_ro;
            p_vertex = vpu_vertex;
            p_flags_we = flags_we;
            p_flags = flags;
            p_key_we = key_we;
            p_keys = keys;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Failure handling and helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping the run");
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        stop_with_failure();
    endtask

    // Returns on the first falling edge with reset released
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            abort_run("reset was never released");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic set_idle();
        {wr_en_0, wr_en_1, vpu_we, flags_we, key_we} = '0;
    endtask

    task automatic idle_cycles(input int n);
        set_idle();
        repeat (n) next_cycle();
    endtask

    task automatic drive_random();
        wr_en_0 = $random(seed);
        wr_en_1 = $random(seed);
        wr_addr_0 = $random(seed);
        wr_addr_1 = (($random(seed) & 3) == 0) ? wr_addr_0 : reg_addr_t'($random(seed));
        wr_data_0 = $random(seed);
        wr_data_1 = $random(seed);
        vpu_we = (($random(seed) & 7) == 0);
        vpu_ro = $random(seed);
        for (int v = 0; v < `VERTEX_COUNT; v++) begin
            vpu_vertex[v] = $random(seed);
        end
        flags_we = (($random(seed) & 3) == 0);
        flags = $random(seed);
        key_we = (($random(seed) & 3) == 0);
        keys = $random(seed);
        rd_addr_0 = $random(seed);
        rd_addr_1 = $random(seed);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Comparing process 10 ns before each rising edge
    //////////////////////////////////////////////////////////////////////

    initial begin
        wait_reset_release();
        forever begin
            #40;
            checks_done++;
            assert (rd_data_0 === model_regs[rd_addr_0]) else report_mismatch($sformatf(
                "rd_data_0 at %0d is %h, expected %h", rd_addr_0, rd_data_0,
                model_regs[rd_addr_0]));
            assert (rd_data_1 === model_regs[rd_addr_1]) else report_mismatch($sformatf(
                "rd_data_1 at %0d is %h, expected %h", rd_addr_1, rd_data_1,
                model_regs[rd_addr_1]));
            assert (ro_word === model_regs[`RO_REG_IDX]) else report_mismatch($sformatf(
                "ro_word is %h, expected %h", ro_word, model_regs[`RO_REG_IDX]));
            for (int v = 0; v < `VERTEX_COUNT; v++) begin
                assert (vertex_words[v] === model_regs[`VERTEX_BASE_IDX + v])
                else report_mismatch($sformatf("vertex_words[%0d] is %h, expected %h",
                    v, vertex_words[v], model_regs[`VERTEX_BASE_IDX + v]));
            end
            @(negedge clk);
        end
    end

    initial begin
        #(MAX_CYCLES * 100);
        abort_run("simulation ran past its cycle limit");
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        rd_addr_0 = '0;
        rd_addr_1 = '0;
        wr_addr_0 = '0;
        wr_addr_1 = '0;
        wr_data_0 = '0;
        wr_data_1 = '0;
        vpu_ro = '0;
        for (int v = 0; v < `VERTEX_COUNT; v++) begin
            vpu_vertex[v] = '0;
        end
        flags = '0;
        keys = '0;
        set_idle();
        wait_reset_release();

        // Every register reads back zero
        for (int i = 0; i < `REG_COUNT; i++) begin
            next_cycle();
            rd_addr_0 = i;
            rd_addr_1 = `REG_COUNT - 1 - i;
        end

        // Two ports on different then on the same address
        next_cycle();
        {wr_en_0, wr_addr_0, wr_data_0} = {1'b1, 5'd3, 16'h1234};
        {wr_en_1, wr_addr_1, wr_data_1} = {1'b1, 5'd7, 16'hc0de};
        rd_addr_0 = 3;
        rd_addr_1 = 7;
        next_cycle();
        {wr_addr_0, wr_data_0, wr_addr_1, wr_data_1} = {5'd10, 16'haaaa, 5'd10, 16'h5555};
        next_cycle();
        rd_addr_0 = 10;
        idle_cycles(3);

        // VPU bulk write against CPU writes to RO and a vertex
        vpu_we = 1'b1;
        vpu_ro = 16'h0f0f;
        for (int v = 0; v < `VERTEX_COUNT; v++) begin
            vpu_vertex[v] = 16'h1000 + v * 16'h0111;
        end
        {wr_en_0, wr_addr_0, wr_data_0} = {1'b1, 5'd26, 16'hdead};
        {wr_en_1, wr_addr_1, wr_data_1} = {1'b1, 5'd23, 16'hbeef};
        rd_addr_0 = 26;
        rd_addr_1 = 23;
        next_cycle();
        idle_cycles(3);

        // Flags register
        rd_addr_0 = `FLAGS_REG_IDX;
        {wr_en_0, wr_addr_0, wr_data_0} = {1'b1, 5'd22, 16'h5a00};
        next_cycle();
        set_idle();
        {flags_we, flags} = {1'b1, 3'b101};
        {wr_en_1, wr_addr_1, wr_data_1} = {1'b1, 5'd22, 16'hffff};
        next_cycle();
        set_idle();
        {key_we, keys} = {1'b1, 5'b00011};
        next_cycle();
        {key_we, keys} = {1'b1, 5'b10000};
        next_cycle();
        {flags_we, flags, key_we, keys} = {1'b1, 3'b010, 1'b1, 5'b01000};
        next_cycle();
        idle_cycles(3);

        // Random traffic on every source
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            drive_random();
            next_cycle();
        end
        idle_cycles(4);

        if (checks_done > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb/clock_gen.sv
// Testbench clock and reset source
// 100 ns clock, arst_n held low over the first 4 rising edges

`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release away from any clock edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #25;
        arst_n = 1'b1;
    end

endmodule

// File: source/regfile_top.sv
// Register file top level shared by CPU and VPU
// Write capture, register array and read stage, writes visible 2 edges later

`timescale 1ns/10ps

`include "regfile_config.svh"

module regfile_top import regfile_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    // CPU read ports
    input  reg_addr_t  rd_addr_0,
    input  reg_addr_t  rd_addr_1,
    // CPU write ports
    input  reg_addr_t  wr_addr_0,
    input  reg_addr_t  wr_addr_1,
    input  reg_word_t  wr_data_0,
    input  reg_word_t  wr_data_1,
    input  logic       wr_en_0,
    input  logic       wr_en_1,
    // VPU bulk write
    input  logic       vpu_we,
    input  reg_word_t  vpu_ro,
    input  reg_word_t  vpu_vertex [`VERTEX_COUNT],
    // Flags and keys
    input  logic       flags_we,
    input  cpu_flags_t flags,
    input  logic       key_we,
    input  key_bits_t  keys,
    // Read data
    output reg_word_t  rd_data_0,
    output reg_word_t  rd_data_1,
    output reg_word_t  ro_word,
    output reg_word_t  vertex_words [`VERTEX_COUNT]
);

    // Captured requests
    reg_addr_t  q_wr_addr_0;
    reg_addr_t  q_wr_addr_1;
    reg_word_t  q_wr_data_0;
    reg_word_t  q_wr_data_1;
    logic       q_wr_en_0;
    logic       q_wr_en_1;
    logic       q_vpu_we;
    reg_word_t  q_vpu_ro;
    reg_word_t  q_vpu_vertex [`VERTEX_COUNT];
    logic       q_flags_we;
    cpu_flags_t q_flags;
    logic       q_key_we;
    key_bits_t  q_keys;

    // Bank contents
    reg_word_t  regs [`REG_COUNT];

    write_capture write_capture_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .wr_addr_0    (wr_addr_0),
        .wr_addr_1    (wr_addr_1),
        .wr_data_0    (wr_data_0),
        .wr_data_1    (wr_data_1),
        .wr_en_0      (wr_en_0),
        .wr_en_1      (wr_en_1),
        .vpu_we       (vpu_we),
        .vpu_ro       (vpu_ro),
        .vpu_vertex   (vpu_vertex),
        .flags_we     (flags_we),
        .flags        (flags),
        .key_we       (key_we),
        .keys         (keys),
        .q_wr_addr_0  (q_wr_addr_0),
        .q_wr_addr_1  (q_wr_addr_1),
        .q_wr_data_0  (q_wr_data_0),
        .q_wr_data_1  (q_wr_data_1),
        .q_wr_en_0    (q_wr_en_0),
        .q_wr_en_1    (q_wr_en_1),
        .q_vpu_we     (q_vpu_we),
        .q_vpu_ro     (q_vpu_ro),
        .q_vpu_vertex (q_vpu_vertex),
        .q_flags_we   (q_flags_we),
        .q_flags      (q_flags),
        .q_key_we     (q_key_we),
        .q_keys       (q_keys)
    );

    register_array register_array_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .q_wr_addr_0  (q_wr_addr_0),
        .q_wr_addr_1  (q_wr_addr_1),
        .q_wr_data_0  (q_wr_data_0),
        .q_wr_data_1  (q_wr_data_1),
        .q_wr_en_0    (q_wr_en_0),
        .q_wr_en_1    (q_wr_en_1),
        .q_vpu_we     (q_vpu_we),
        .q_vpu_ro     (q_vpu_ro),
        .q_vpu_vertex (q_vpu_vertex),
        .q_flags_we   (q_flags_we),
        .q_flags      (q_flags),
        .q_key_we     (q_key_we),
        .q_keys       (q_keys),
        .regs         (regs)
    );

    read_ports read_ports_inst (
        .regs         (regs),
        .rd_addr_0    (rd_addr_0),
        .rd_addr_1    (rd_addr_1),
        .rd_data_0    (rd_data_0),
        .rd_data_1    (rd_data_1),
        .ro_word      (ro_word),
        .vertex_words (vertex_words)
    );

endmodule

// File: source/read_ports.sv
// Combinational read stage
// Two CPU read ports plus fixed taps of the RO and vertex registers for the VPU

`timescale 1ns/10ps

`include "regfile_config.svh"

module read_ports import regfile_pkg::*; (
    input  reg_word_t regs [`REG_COUNT],
    input  reg_addr_t rd_addr_0,
    input  reg_addr_t rd_addr_1,
    output reg_word_t rd_data_0,
    output reg_word_t rd_data_1,
    output reg_word_t ro_word,
    output reg_word_t vertex_words [`VERTEX_COUNT]
);

    //////////////////////////////////////////////////////////////////////
    // CPU read ports
    //////////////////////////////////////////////////////////////////////

    // Address covers the full bank, no out of range case
    assign rd_data_0 = regs[rd_addr_0];
    assign rd_data_1 = regs[rd_addr_1];

    //////////////////////////////////////////////////////////////////////
    // VPU taps
    //////////////////////////////////////////////////////////////////////

    assign ro_word = regs[`RO_REG_IDX];

    always_comb begin
        for (int v = 0; v < `VERTEX_COUNT; v++) begin
            vertex_words[v] = regs[`VERTEX_BASE_IDX + v];
        end
    end

endmodule

// File: source/register_array.sv
// The 32 registers shared by CPU and VPU
// Applies the captured write requests with a fixed per-register priority

`timescale 1ns/10ps

`include "regfile_config.svh"

module register_array import regfile_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    // Captured CPU writes
    input  reg_addr_t  q_wr_addr_0,
    input  reg_addr_t  q_wr_addr_1,
    input  reg_word_t  q_wr_data_0,
    input  reg_word_t  q_wr_data_1,
    input  logic       q_wr_en_0,
    input  logic       q_wr_en_1,
    // Captured VPU bulk write
    input  logic       q_vpu_we,
    input  reg_word_t  q_vpu_ro,
    input  reg_word_t  q_vpu_vertex [`VERTEX_COUNT],
    // Captured flags and key updates
    input  logic       q_flags_we,
    input  cpu_flags_t q_flags,
    input  logic       q_key_we,
    input  key_bits_t  q_keys,
    // Register bank contents
    output reg_word_t  regs [`REG_COUNT]
);

    // Per-register hits of port A and port B
    logic [`REG_COUNT-1:0] we_a;
    logic [`REG_COUNT-1:0] we_b;

    reg_word_t next_regs [`REG_COUNT];

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            we_a[i] = q_wr_en_0 && (q_wr_addr_0 == reg_addr_t'(i));
            we_b[i] = q_wr_en_1 && (q_wr_addr_1 == reg_addr_t'(i));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next value selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // General rule, port A over port B
        for (int i = 0; i < `REG_COUNT; i++) begin
            if (we_a[i]) begin
                next_regs[i] = q_wr_data_0;
            end else if (we_b[i]) begin
                next_regs[i] = q_wr_data_1;
            end else begin
                next_regs[i] = regs[i];
            end
        end

        // VPU bulk write overrides the CPU on RO and vertices
        if (q_vpu_we) begin
            next_regs[`RO_REG_IDX] = q_vpu_ro;
            for (int v = 0; v < `VERTEX_COUNT; v++) begin
                next_regs[`VERTEX_BASE_IDX + v] = q_vpu_vertex[v];
            end
        end

        // Flags register, flags update first, then keys
        if (q_flags_we) begin
            next_regs[`FLAGS_REG_IDX] = regs[`FLAGS_REG_IDX];
            next_regs[`FLAGS_REG_IDX][`FLAG_BITS-1:0] = q_flags;
        end else if (q_key_we) begin
            next_regs[`FLAGS_REG_IDX] = regs[`FLAGS_REG_IDX];
            // Keys stay latched until software clears them
            next_regs[`FLAGS_REG_IDX][`KEY_LSB +: `KEY_BITS] =
                regs[`FLAGS_REG_IDX][`KEY_LSB +: `KEY_BITS] | q_keys;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= next_regs[i];
            end
        end
    end

endmodule

// File: source/write_capture.sv
// First pipeline stage of the register file
// Registers every write request so the array sees edge-aligned requests

`timescale 1ns/10ps

`include "regfile_config.svh"

module write_capture import regfile_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    // CPU write ports
    input  reg_addr_t  wr_addr_0,
    input  reg_addr_t  wr_addr_1,
    input  reg_word_t  wr_data_0,
    input  reg_word_t  wr_data_1,
    input  logic       wr_en_0,
    input  logic       wr_en_1,
    // VPU bulk write
    input  logic       vpu_we,
    input  reg_word_t  vpu_ro,
    input  reg_word_t  vpu_vertex [`VERTEX_COUNT],
    // Flags and key updates
    input  logic       flags_we,
    input  cpu_flags_t flags,
    input  logic       key_we,
    input  key_bits_t  keys,
    // Registered copies
    output reg_addr_t  q_wr_addr_0,
    output reg_addr_t  q_wr_addr_1,
    output reg_word_t  q_wr_data_0,
    output reg_word_t  q_wr_data_1,
    output logic       q_wr_en_0,
    output logic       q_wr_en_1,
    output logic       q_vpu_we,
    output reg_word_t  q_vpu_ro,
    output reg_word_t  q_vpu_vertex [`VERTEX_COUNT],
    output logic       q_flags_we,
    output cpu_flags_t q_flags,
    output logic       q_key_we,
    output key_bits_t  q_keys
);

    //////////////////////////////////////////////////////////////////////
    // Write enables
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_wr_en_0  <= 1'b0;
            q_wr_en_1  <= 1'b0;
            q_vpu_we   <= 1'b0;
            q_flags_we <= 1'b0;
            q_key_we   <= 1'b0;
        end else begin
            q_wr_en_0  <= wr_en_0;
            q_wr_en_1  <= wr_en_1;
            q_vpu_we   <= vpu_we;
            q_flags_we <= flags_we;
            q_key_we   <= key_we;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request payload, only loaded with its enable
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en_0) begin
            q_wr_addr_0 <= wr_addr_0;
            q_wr_data_0 <= wr_data_0;
        end
        if (wr_en_1) begin
            q_wr_addr_1 <= wr_addr_1;
            q_wr_data_1 <= wr_data_1;
        end
        // Whole vertex block moves together
        if (vpu_we) begin
            q_vpu_ro     <= vpu_ro;
            q_vpu_vertex <= vpu_vertex;
        end
        if (flags_we) begin
            q_flags <= flags;
        end
        if (key_we) begin
            q_keys <= keys;
        end
    end

endmodule

// File: source/regfile_pkg.sv
// Shared types of the register file
// Modules take these through a wildcard import in their header

`include "regfile_config.svh"

package regfile_pkg;

    // Register address and contents
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`REG_WORD_W-1:0] reg_word_t;

    // Condition flags Z, N, V
    typedef logic [`FLAG_BITS-1:0] cpu_flags_t;

    // Key presses from the serial port
    typedef logic [`KEY_BITS-1:0] key_bits_t;

endpackage

// File: include/regfile_config.svh
// Sizing and register map of the shared CPU/VPU register file
// Include wherever a width, a count or a special register index is needed

`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// Register bank geometry
`define REG_COUNT       32
`define REG_ADDR_W      5
`define REG_WORD_W      16

// Special registers
`define FLAGS_REG_IDX   22
`define RO_REG_IDX      23
`define VERTEX_BASE_IDX 24
`define VERTEX_COUNT    8

// Flags register layout, Z N V in the low bits, key presses above
`define FLAG_BITS       3
`define KEY_BITS        5
`define KEY_LSB         3

`endif
